/* build.f */
common/matrix_pkg.sv
common/alu_ctrl_pkg.sv
alu_core/index_counter.sv
alu_core/element_datapath.sv
alu_core/alu_fsm.sv
rtl/matrix_alu_top.sv
sim/tb_matrix_alu.sv

/* Makefile */
# Verilator build, run, lint and clean for the matrix ALU

TOP := tb_matrix_alu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f

# The log decides the result
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module matrix_alu_top -f build.f

clean:
	rm -rf obj_dir sim.log

/* sim/tb_matrix_alu.sv */
// Testbench for matrix_alu_top with storage model, random operations and reference model
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_alu;

  import matrix_pkg::*;
  import alu_ctrl_pkg::*;

  localparam int ELEM_W  = DEF_ELEM_W;
  localparam int IDX_W   = DEF_IDX_W;
  localparam int ACC_W   = DEF_ACC_W;
  localparam int CYC_W   = DEF_CYC_W;
  // Longest run is 8x8x8 steps of 3 cycles
  localparam int TIMEOUT = 4000;
  localparam int RUNS    = 36;

  logic clk = 1'b0;
  logic rst_n;
  logic start_i;
  op_code_t op_code;
  logic signed [ELEM_W-1:0] rd_val_a = '0;
  logic signed [ELEM_W-1:0] rd_val_b = '0;
  logic signed [ELEM_W-1:0] scalar_val;
  logic [IDX_W-1:0] dims_r_a;
  logic [IDX_W-1:0] dims_c_a;
  logic [IDX_W-1:0] dims_r_b;
  logic [IDX_W-1:0] dims_c_b;
  logic [IDX_W-1:0] rd_row_a;
  logic [IDX_W-1:0] rd_col_a;
  logic [IDX_W-1:0] rd_row_b;
  logic [IDX_W-1:0] rd_col_b;
  logic done_o;
  logic error_o;
  logic wr_en_o;
  logic wr_new_o;
  logic [CYC_W-1:0] cycle_cnt_o;
  logic [IDX_W-1:0] wr_dims_r_o;
  logic [IDX_W-1:0] wr_dims_c_o;
  logic [IDX_W-1:0] wr_row_o;
  logic [IDX_W-1:0] wr_col_o;
  logic signed [ELEM_W-1:0] wr_val_o;

  // Storage contents, result capture and write-port bookkeeping
  int mem_a [16][16];
  int mem_b [16][16];
  int res [16][16];
  bit seen [16][16];
  int scalar_int;
  int wr_cnt;
  int new_cnt;
  int early_wr;
  int new_r;
  int new_c;
  int checks;
  int errors;
  int timeouts;

  always #2 clk = ~clk;

  matrix_alu_top #(
    .ELEM_W (ELEM_W),
    .IDX_W  (IDX_W),
    .ACC_W  (ACC_W),
    .CYC_W  (CYC_W)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .op_code_i     (op_code),
    .rd_row_a_o    (rd_row_a),
    .rd_col_a_o    (rd_col_a),
    .rd_val_a_i    (rd_val_a),
    .rd_dims_r_a_i (dims_r_a),
    .rd_dims_c_a_i (dims_c_a),
    .rd_row_b_o    (rd_row_b),
    .rd_col_b_o    (rd_col_b),
    .rd_val_b_i    (rd_val_b),
    .rd_dims_r_b_i (dims_r_b),
    .rd_dims_c_b_i (dims_c_b),
    .scalar_val_i  (scalar_val),
    .done_o        (done_o),
    .error_o       (error_o),
    .cycle_cnt_o   (cycle_cnt_o),
    .wr_en_o       (wr_en_o),
    .wr_new_o      (wr_new_o),
    .wr_dims_r_o   (wr_dims_r_o),
    .wr_dims_c_o   (wr_dims_c_o),
    .wr_row_o      (wr_row_o),
    .wr_col_o      (wr_col_o),
    .wr_val_o      (wr_val_o)
  );

  // ------------------------------
  // Storage model and write monitor
  // ------------------------------
  // Read data lags the address by one cycle
  always @(posedge clk) begin
    rd_val_a <= ELEM_W'(mem_a[rd_row_a][rd_col_a]);
    rd_val_b <= ELEM_W'(mem_b[rd_row_b][rd_col_b]);
  end

  always @(posedge clk) begin
    if (wr_new_o) begin
      new_cnt++;
      new_r = int'(wr_dims_r_o);
      new_c = int'(wr_dims_c_o);
    end
    if (wr_en_o) begin
      // A write with no allocation ahead of it
      if (new_cnt == 0) begin
        early_wr++;
      end
      wr_cnt++;
      res[wr_row_o][wr_col_o] = int'(wr_val_o);
      seen[wr_row_o][wr_col_o] = 1'b1;
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int clamp_elem(input int v);
    int hi;
    int lo;
    hi = (1 << (ELEM_W - 1)) - 1;
    lo = -(1 << (ELEM_W - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  function automatic int expect_val(input op_code_t op, input int i, input int j, input int kn);
    int acc;
    acc = 0;
    case (op)
      OP_ADD:        acc = mem_a[i][j] + mem_b[i][j];
      OP_SCALAR_MUL: acc = mem_a[i][j] * scalar_int;
      OP_TRANSPOSE:  return mem_a[j][i];
      // Full-width dot product, clamped once at the end
      default: begin
        for (int k = 0; k < kn; k++) begin
          acc += mem_a[i][k] * mem_b[k][j];
        end
      end
    endcase
    return clamp_elem(acc);
  endfunction

  // Biased toward both ends of the range so add saturates either way
  function automatic int rand_elem();
    int sel;
    sel = int'($urandom % 4);
    if (sel == 0) return 100 + int'($urandom % 28);
    if (sel == 1) return -128 + int'($urandom % 28);
    return int'($urandom % 256) - 128;
  endfunction

  task automatic check_val(input string name, input int got, input int exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got=%h exp=%h", name, got, exp);
    end
  endtask

  // Fill every address, clear capture, run one operation and check it
  task automatic run_op(input op_code_t op, input int ra, input int ca, input int rb,
                        input int cb, input bit bad);
    int t;
    int kn;
    int er;
    int ec;
    kn = (op == OP_MAT_MUL) ? ca : 1;
    er = (op == OP_TRANSPOSE) ? ca : ra;
    ec = (op == OP_MAT_MUL) ? cb : ((op == OP_TRANSPOSE) ? ra : ca);
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) begin
        mem_a[r][c] = rand_elem();
        mem_b[r][c] = rand_elem();
        seen[r][c] = 1'b0;
      end
    end
    scalar_int = int'($urandom % 256) - 128;
    wr_cnt = 0;
    new_cnt = 0;
    early_wr = 0;
    @(posedge clk);
    op_code    <= op;
    dims_r_a   <= IDX_W'(ra);
    dims_c_a   <= IDX_W'(ca);
    dims_r_b   <= IDX_W'(rb);
    dims_c_b   <= IDX_W'(cb);
    scalar_val <= ELEM_W'(scalar_int);
    start_i    <= 1'b1;
    t = 0;
    while (!done_o && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (!done_o) begin
      $display("Timeout: done_o never rose for op %0d", op);
      timeouts++;
      return;
    end
    check_val("error_o", int'(error_o), int'(bad));
    check_val("cycle_cnt_o", int'(cycle_cnt_o), bad ? 0 : 3 * er * ec * kn);
    start_i <= 1'b0;
    t = 0;
    while (done_o && t < 8) begin
      @(posedge clk);
      t++;
    end
    if (done_o) begin
      $display("Timeout: done_o stayed high after start_i fell");
      timeouts++;
      return;
    end
    check_val("wr_new_o pulses", new_cnt, bad ? 0 : 1);
    check_val("wr_en_o pulses", wr_cnt, bad ? 0 : er * ec);
    check_val("wr_en_o before wr_new_o", early_wr, 0);
    if (!bad) begin
      check_val("wr_dims_r_o", new_r, er);
      check_val("wr_dims_c_o", new_c, ec);
      for (int i = 0; i < er; i++) begin
        for (int j = 0; j < ec; j++) begin
          if (!seen[i][j]) begin
            errors++;
            $display("Result element (%0d,%0d) was never written", i, j);
          end
          check_val($sformatf("wr_val_o[%0d][%0d]", i, j), res[i][j],
                    expect_val(op, i, j, kn));
        end
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int ra;
    int ca;
    int cb;
    void'($urandom(31887));
    checks = 0;
    errors = 0;
    timeouts = 0;
    rst_n = 1'b0;
    start_i = 1'b0;
    op_code = OP_ADD;
    scalar_val = '0;
    dims_r_a = '0;
    dims_c_a = '0;
    dims_r_b = '0;
    dims_c_b = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Idle outputs after reset
    check_val("done_o", int'(done_o), 0);
    check_val("error_o", int'(error_o), 0);
    check_val("wr_en_o", int'(wr_en_o), 0);
    check_val("wr_new_o", int'(wr_new_o), 0);
    check_val("cycle_cnt_o", int'(cycle_cnt_o), 0);
    for (int n = 0; n < RUNS && timeouts == 0; n++) begin
      ra = 1 + int'($urandom % 8);
      ca = 1 + int'($urandom % 8);
      cb = 1 + int'($urandom % 8);
      case (n % 6)
        0: run_op(OP_ADD, ra, ca, ra, ca, 1'b0);
        1: run_op(OP_SCALAR_MUL, ra, ca, cb, ra, 1'b0);
        2: run_op(OP_TRANSPOSE, ra, ca, cb, ra, 1'b0);
        3: run_op(OP_MAT_MUL, ra, ca, ca, cb, 1'b0);
        // Row or column count of B differs from A
        4: begin
          if (cb % 2 == 0) begin
            run_op(OP_ADD, ra, ca, ra, (ca % 8) + 1, 1'b1);
          end else begin
            run_op(OP_ADD, ra, ca, (ra % 8) + 1, ca, 1'b1);
          end
        end
        default: run_op(OP_MAT_MUL, ra, ca, (ca % 8) + 1, cb, 1'b1);
      endcase
    end
    $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/matrix_alu_top.sv */
// Matrix ALU top level with sequencing FSM, index counters and element datapath
`timescale 1ns/1ps
`default_nettype none

module matrix_alu_top #(
  parameter int ELEM_W = matrix_pkg::DEF_ELEM_W,
  parameter int IDX_W  = matrix_pkg::DEF_IDX_W,
  parameter int ACC_W  = matrix_pkg::DEF_ACC_W,
  parameter int CYC_W  = matrix_pkg::DEF_CYC_W
) (
  input  wire                          clk,
  input  wire                          rst_n,

  // Run control
  input  wire                          start_i,
  input  wire alu_ctrl_pkg::op_code_t  op_code_i,

  // Scalar read ports A and B
  output logic        [IDX_W-1:0]      rd_row_a_o,
  output logic        [IDX_W-1:0]      rd_col_a_o,
  input  wire  signed [ELEM_W-1:0]     rd_val_a_i,
  input  wire         [IDX_W-1:0]      rd_dims_r_a_i,
  input  wire         [IDX_W-1:0]      rd_dims_c_a_i,
  output logic        [IDX_W-1:0]      rd_row_b_o,
  output logic        [IDX_W-1:0]      rd_col_b_o,
  input  wire  signed [ELEM_W-1:0]     rd_val_b_i,
  input  wire         [IDX_W-1:0]      rd_dims_r_b_i,
  input  wire         [IDX_W-1:0]      rd_dims_c_b_i,
  input  wire  signed [ELEM_W-1:0]     scalar_val_i,

  // Status
  output logic                         done_o,
  output logic                         error_o,
  output logic        [CYC_W-1:0]      cycle_cnt_o,

  // Result write port
  output logic                         wr_en_o,
  output logic                         wr_new_o,
  output logic        [IDX_W-1:0]      wr_dims_r_o,
  output logic        [IDX_W-1:0]      wr_dims_c_o,
  output logic        [IDX_W-1:0]      wr_row_o,
  output logic        [IDX_W-1:0]      wr_col_o,
  output logic signed [ELEM_W-1:0]     wr_val_o
);

  // ------------------------------
  // Loop control between FSM and counters
  // ------------------------------
  logic [IDX_W-1:0] limit_i;
  logic [IDX_W-1:0] limit_j;
  logic [IDX_W-1:0] limit_k;
  logic             cnt_clear;
  logic             cnt_step;
  logic             run_end;

  // Datapath control
  logic             calc;
  logic [IDX_W-1:0] idx_i;
  logic [IDX_W-1:0] idx_j;
  logic [IDX_W-1:0] idx_k;
  logic             last_k;

  alu_fsm #(
    .IDX_W (IDX_W),
    .CYC_W (CYC_W)
  ) u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start_i),
    .op_code_i     (op_code_i),
    .rd_dims_r_a_i (rd_dims_r_a_i),
    .rd_dims_c_a_i (rd_dims_c_a_i),
    .rd_dims_r_b_i (rd_dims_r_b_i),
    .rd_dims_c_b_i (rd_dims_c_b_i),
    .run_end_i     (run_end),
    .done_o        (done_o),
    .error_o       (error_o),
    .cycle_cnt_o   (cycle_cnt_o),
    .wr_new_o      (wr_new_o),
    .wr_dims_r_o   (wr_dims_r_o),
    .wr_dims_c_o   (wr_dims_c_o),
    .cnt_clear_o   (cnt_clear),
    .cnt_step_o    (cnt_step),
    .calc_o        (calc),
    .limit_i_o     (limit_i),
    .limit_j_o     (limit_j),
    .limit_k_o     (limit_k)
  );

  index_counter #(
    .IDX_W (IDX_W)
  ) u_idx (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_i   (cnt_clear),
    .step_i    (cnt_step),
    .limit_i_i (limit_i),
    .limit_j_i (limit_j),
    .limit_k_i (limit_k),
    .idx_i_o   (idx_i),
    .idx_j_o   (idx_j),
    .idx_k_o   (idx_k),
    .last_k_o  (last_k),
    .run_end_o (run_end)
  );

  element_datapath #(
    .ELEM_W (ELEM_W),
    .IDX_W  (IDX_W),
    .ACC_W  (ACC_W)
  ) u_dp (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_code_i    (op_code_i),
    .calc_i       (calc),
    .idx_i_i      (idx_i),
    .idx_j_i      (idx_j),
    .idx_k_i      (idx_k),
    .last_k_i     (last_k),
    .rd_val_a_i   (rd_val_a_i),
    .rd_val_b_i   (rd_val_b_i),
    .scalar_val_i (scalar_val_i),
    .rd_row_a_o   (rd_row_a_o),
    .rd_col_a_o   (rd_col_a_o),
    .rd_row_b_o   (rd_row_b_o),
    .rd_col_b_o   (rd_col_b_o),
    .wr_en_o      (wr_en_o),
    .wr_row_o     (wr_row_o),
    .wr_col_o     (wr_col_o),
    .wr_val_o     (wr_val_o)
  );

endmodule

`default_nettype wire

/* alu_core/alu_fsm.sv */
// Sequencing FSM with shape check, result allocation, step pacing and cycle count
`timescale 1ns/1ps
`default_nettype none

module alu_fsm #(
  parameter int IDX_W = matrix_pkg::DEF_IDX_W,
  parameter int CYC_W = matrix_pkg::DEF_CYC_W
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         start_i,
  input  wire alu_ctrl_pkg::op_code_t op_code_i,
  input  wire  [IDX_W-1:0]            rd_dims_r_a_i,
  input  wire  [IDX_W-1:0]            rd_dims_c_a_i,
  input  wire  [IDX_W-1:0]            rd_dims_r_b_i,
  input  wire  [IDX_W-1:0]            rd_dims_c_b_i,
  input  wire                         run_end_i,
  output logic                        done_o,
  output logic                        error_o,
  output logic [CYC_W-1:0]            cycle_cnt_o,
  output logic                        wr_new_o,
  output logic [IDX_W-1:0]            wr_dims_r_o,
  output logic [IDX_W-1:0]            wr_dims_c_o,
  output logic                        cnt_clear_o,
  output logic                        cnt_step_o,
  output logic                        calc_o,
  output logic [IDX_W-1:0]            limit_i_o,
  output logic [IDX_W-1:0]            limit_j_o,
  output logic [IDX_W-1:0]            limit_k_o
);

  import alu_ctrl_pkg::*;

  alu_state_t       state_q;
  logic [CYC_W-1:0] perf_cnt;

  // Shape decode of the selected operation
  logic             shape_ok;
  logic             op_known;
  logic [IDX_W-1:0] res_rows;
  logic [IDX_W-1:0] res_cols;
  logic [IDX_W-1:0] dot_len;

  always_comb begin
    shape_ok = 1'b1;
    op_known = 1'b1;
    res_rows = rd_dims_r_a_i;
    res_cols = rd_dims_c_a_i;
    // Single term per cell unless matrix multiply
    dot_len  = IDX_W'(1);
    case (op_code_i)
      OP_ADD:        shape_ok = (rd_dims_r_a_i == rd_dims_r_b_i) &&
                                (rd_dims_c_a_i == rd_dims_c_b_i);
      OP_SCALAR_MUL: shape_ok = 1'b1;
      OP_TRANSPOSE: begin
        res_rows = rd_dims_c_a_i;
        res_cols = rd_dims_r_a_i;
      end
      OP_MAT_MUL: begin
        // Inner dimensions must agree
        shape_ok = (rd_dims_c_a_i == rd_dims_r_b_i);
        res_cols = rd_dims_c_b_i;
        dot_len  = rd_dims_c_a_i;
      end
      default:       op_known = 1'b0;
    endcase
  end

  // Counter clears while shapes are decoded, steps once per CALC
  assign cnt_clear_o = (state_q == PREPARE);
  assign cnt_step_o  = (state_q == CALC);
  assign calc_o      = (state_q == CALC);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      done_o      <= 1'b0;
      error_o     <= 1'b0;
      cycle_cnt_o <= '0;
      perf_cnt    <= '0;
      wr_new_o    <= 1'b0;
      wr_dims_r_o <= '0;
      wr_dims_c_o <= '0;
      limit_i_o   <= '0;
      limit_j_o   <= '0;
      limit_k_o   <= '0;
    end else begin
      // Allocation is a single-cycle pulse
      wr_new_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            error_o  <= 1'b0;
            perf_cnt <= '0;
            state_q  <= PREPARE;
          end
        end
        // ------------------------------
        // Shape check and loop setup
        // ------------------------------
        PREPARE: begin
          if (op_known && shape_ok) begin
            wr_dims_r_o <= res_rows;
            wr_dims_c_o <= res_cols;
            limit_i_o   <= res_rows;
            limit_j_o   <= res_cols;
            limit_k_o   <= dot_len;
            wr_new_o    <= 1'b1;
            state_q     <= ALLOC;
          end else begin
            // Bad shape flags an error, unknown op ends quietly
            error_o     <= op_known;
            cycle_cnt_o <= '0;
            done_o      <= 1'b1;
            state_q     <= DONE;
          end
        end
        ALLOC: state_q <= FETCH;
        // ------------------------------
        // Three-cycle step
        // ------------------------------
        FETCH: begin
          perf_cnt <= perf_cnt + CYC_W'(1);
          state_q  <= WAIT;
        end
        WAIT: begin
          perf_cnt <= perf_cnt + CYC_W'(1);
          state_q  <= CALC;
        end
        CALC: begin
          perf_cnt <= perf_cnt + CYC_W'(1);
          if (run_end_i) begin
            // Include this CALC cycle in the latched count
            cycle_cnt_o <= perf_cnt + CYC_W'(1);
            done_o      <= 1'b1;
            state_q     <= DONE;
          end else begin
            state_q <= FETCH;
          end
        end
        DONE: begin
          if (!start_i) begin
            done_o  <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* alu_core/element_datapath.sv */
// Read address mapping, term arithmetic, accumulation, saturation and write registers
`timescale 1ns/1ps
`default_nettype none

module element_datapath #(
  parameter int ELEM_W = matrix_pkg::DEF_ELEM_W,
  parameter int IDX_W  = matrix_pkg::DEF_IDX_W,
  parameter int ACC_W  = matrix_pkg::DEF_ACC_W
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire alu_ctrl_pkg::op_code_t op_code_i,
  input  wire                         calc_i,
  input  wire         [IDX_W-1:0]     idx_i_i,
  input  wire         [IDX_W-1:0]     idx_j_i,
  input  wire         [IDX_W-1:0]     idx_k_i,
  input  wire                         last_k_i,
  input  wire  signed [ELEM_W-1:0]    rd_val_a_i,
  input  wire  signed [ELEM_W-1:0]    rd_val_b_i,
  input  wire  signed [ELEM_W-1:0]    scalar_val_i,
  output logic        [IDX_W-1:0]     rd_row_a_o,
  output logic        [IDX_W-1:0]     rd_col_a_o,
  output logic        [IDX_W-1:0]     rd_row_b_o,
  output logic        [IDX_W-1:0]     rd_col_b_o,
  output logic                        wr_en_o,
  output logic        [IDX_W-1:0]     wr_row_o,
  output logic        [IDX_W-1:0]     wr_col_o,
  output logic signed [ELEM_W-1:0]    wr_val_o
);

  import alu_ctrl_pkg::*;
  import matrix_pkg::*;

  // Clamp bounds at accumulator width
  localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(elem_max(ELEM_W));
  localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(elem_min(ELEM_W));

  logic signed [ACC_W-1:0]  a_ext;
  logic signed [ACC_W-1:0]  b_ext;
  logic signed [ACC_W-1:0]  s_ext;
  logic signed [ACC_W-1:0]  term;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [ACC_W-1:0]  acc_sum;
  logic signed [ELEM_W-1:0] sat_val;

  // ------------------------------
  // Read addresses from live indices
  // ------------------------------
  always_comb begin
    rd_row_a_o = idx_i_i;
    rd_col_a_o = idx_j_i;
    rd_row_b_o = idx_i_i;
    rd_col_b_o = idx_j_i;
    case (op_code_i)
      // Result (i,j) is A(j,i)
      OP_TRANSPOSE: begin
        rd_row_a_o = idx_j_i;
        rd_col_a_o = idx_i_i;
      end
      // A(i,k) times B(k,j)
      OP_MAT_MUL: begin
        rd_col_a_o = idx_k_i;
        rd_row_b_o = idx_k_i;
      end
      default: ;
    endcase
  end

  // Sign-extended operands
  assign a_ext = rd_val_a_i;
  assign b_ext = rd_val_b_i;
  assign s_ext = scalar_val_i;

  // Term added per step
  always_comb begin
    case (op_code_i)
      OP_ADD:        term = a_ext + b_ext;
      OP_SCALAR_MUL: term = a_ext * s_ext;
      OP_MAT_MUL:    term = a_ext * b_ext;
      default:       term = a_ext;
    endcase
  end

  assign acc_sum = acc_q + term;

  // Clamp to element range, transpose copies A as is
  always_comb begin
    if (op_code_i == OP_TRANSPOSE) begin
      sat_val = rd_val_a_i;
    end else if (acc_sum > SAT_MAX) begin
      sat_val = SAT_MAX[ELEM_W-1:0];
    end else if (acc_sum < SAT_MIN) begin
      sat_val = SAT_MIN[ELEM_W-1:0];
    end else begin
      sat_val = acc_sum[ELEM_W-1:0];
    end
  end

  // Accumulator restarts after each written cell
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q   <= '0;
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= calc_i & last_k_i;
      if (calc_i) begin
        acc_q <= last_k_i ? '0 : acc_sum;
      end
    end
  end

  // Write payload, qualified by wr_en_o
  always_ff @(posedge clk) begin
    if (calc_i && last_k_i) begin
      wr_row_o <= idx_i_i;
      wr_col_o <= idx_j_i;
      wr_val_o <= sat_val;
    end
  end

endmodule

`default_nettype wire

/* alu_core/index_counter.sv */
// Nested row, column and dot-product index counters with end flags
`timescale 1ns/1ps
`default_nettype none

module index_counter #(
  parameter int IDX_W = matrix_pkg::DEF_IDX_W
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              clear_i,
  input  wire              step_i,
  input  wire  [IDX_W-1:0] limit_i_i,
  input  wire  [IDX_W-1:0] limit_j_i,
  input  wire  [IDX_W-1:0] limit_k_i,
  output logic [IDX_W-1:0] idx_i_o,
  output logic [IDX_W-1:0] idx_j_o,
  output logic [IDX_W-1:0] idx_k_o,
  output logic             last_k_o,
  output logic             run_end_o
);

  logic last_j;
  logic last_i;

  // Limits are dimensions
  // Last index of each level is limit minus one
  assign last_k_o  = (idx_k_o == limit_k_i - IDX_W'(1));
  assign last_j    = (idx_j_o == limit_j_i - IDX_W'(1));
  assign last_i    = (idx_i_o == limit_i_i - IDX_W'(1));

  // Last term of the last cell
  assign run_end_o = last_k_o & last_j & last_i;

  // ------------------------------
  // k innermost, then j, then i
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_i_o <= '0;
      idx_j_o <= '0;
      idx_k_o <= '0;
    end else if (clear_i) begin
      idx_i_o <= '0;
      idx_j_o <= '0;
      idx_k_o <= '0;
    end else if (step_i) begin
      if (last_k_o) begin
        idx_k_o <= '0;
        if (last_j) begin
          idx_j_o <= '0;
          // Row wraps back to zero after the final cell
          idx_i_o <= last_i ? '0 : idx_i_o + IDX_W'(1);
        end else begin
          idx_j_o <= idx_j_o + IDX_W'(1);
        end
      end else begin
        idx_k_o <= idx_k_o + IDX_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* common/alu_ctrl_pkg.sv */
// Operation codes and state encoding of the sequencing FSM
`default_nettype none

package alu_ctrl_pkg;

  // Operation select
  // Codes 4 to 7 are unknown and end the run without an error
  typedef enum logic [2:0] {
    OP_ADD        = 3'd0,
    OP_SCALAR_MUL = 3'd1,
    OP_TRANSPOSE  = 3'd2,
    OP_MAT_MUL    = 3'd3
  } op_code_t;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    PREPARE = 3'd1,  // shape check and result dims
    ALLOC   = 3'd2,  // result allocation pulse
    FETCH   = 3'd3,  // indices drive read addresses
    WAIT    = 3'd4,  // storage read latency
    CALC    = 3'd5,  // accumulate, write on last k
    DONE    = 3'd6
  } alu_state_t;

endpackage

`default_nettype wire

/* common/matrix_pkg.sv */
// Default datapath widths and signed saturation bounds for matrix elements
`default_nettype none

package matrix_pkg;

  // ------------------------------
  // Default widths
  // ------------------------------

  // Signed matrix element
  localparam int DEF_ELEM_W = 8;

  // Row, column and dimension values, dims 1 to 8
  localparam int DEF_IDX_W = 4;

  // Dot-product accumulator
  // Holds 8 full products of two 8-bit elements with headroom
  localparam int DEF_ACC_W = 24;

  // Compute cycle counter
  localparam int DEF_CYC_W = 32;

  // ------------------------------
  // Saturation bounds
  // ------------------------------

  // Largest signed value of an elem_w-bit element
  function automatic int elem_max(input int elem_w);
    return (1 <<< (elem_w - 1)) - 1;
  endfunction

  // Smallest signed value of an elem_w-bit element
  function automatic int elem_min(input int elem_w);
    return -(1 <<< (elem_w - 1));
  endfunction

endpackage

`default_nettype wire
